/* flist.f */
+incdir+hdl
hdl/psx_pkg.sv
hdl/psx_bit_clock.sv
hdl/psx_byte_shifter.sv
hdl/psx_poll_ctrl.sv
hdl/psx_pad_emulator.sv
hdl/psx_pad_link.sv
test/tb_psx_pad_link.sv

/* hdl/psx_bit_clock.sv */
`include "psx_defs.svh"

module psx_bit_clock (
    input  logic clk,
    input  logic rst,
    input  logic run,       // High while a byte is clocked
    output logic psx_clk,   // Idles high
    output logic fall_stb,  // High in the cycle psx_clk goes low
    output logic rise_stb   // High in the cycle psx_clk goes high
);

    // Wide enough for a half period of one cycle too
    localparam int CNT_W = $clog2(`PSX_CLK_HALF + 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`PSX_CLK_HALF - 1);

    logic [CNT_W-1:0] half_cnt;  // Cycles into the current half period
    logic             half_end;  // Last cycle of a half period

    assign half_end = (half_cnt == HALF_LAST);

    // First fall comes one full half period after run rises
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            half_cnt <= '0;
            psx_clk  <= 1'b1;  // Parked high between bytes
            fall_stb <= 1'b0;
            rise_stb <= 1'b0;
        end else begin
            // Strobes line up with the psx_clk register
            fall_stb <= half_end && psx_clk;
            rise_stb <= half_end && !psx_clk;
            if (half_end) begin
                half_cnt <= '0;
                psx_clk  <= !psx_clk;  // Toggle at end of half
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/psx_byte_shifter.sv */
module psx_byte_shifter import psx_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      load,       // Start of a byte
    input  psx_byte_t tx_byte,    // Command byte to send
    input  logic      fall_stb,   // psx_clk just fell
    input  logic      rise_stb,   // psx_clk just rose
    input  logic      data,       // Pad to host line
    output logic      cmd,        // Host to pad line
    output psx_byte_t rx_byte,    // Response byte, LSB first
    output logic      byte_done   // One cycle after the eighth rise
);

    psx_byte_t  tx_q;     // Command bits not yet sent
    logic [2:0] bit_cnt;  // Samples taken in this byte

    // Command shift, refilled with ones
    always_ff @(posedge clk) begin
        if (load) begin
            tx_q <= tx_byte;
        end else if (fall_stb) begin
            tx_q <= {1'b1, tx_q[7:1]};
        end
    end

    // Response shift, new bit enters at the top
    always_ff @(posedge clk) begin
        if (rise_stb) begin
            rx_byte <= {data, rx_byte[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd       <= 1'b1;
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;  // Pulse only
            if (load) begin
                cmd     <= 1'b1;  // Line idles high before the first fall
                bit_cnt <= '0;
            end else begin
                if (fall_stb) begin
                    cmd <= tx_q[0];  // Bit valid through the next rise
                end
                if (rise_stb) begin
                    bit_cnt   <= bit_cnt + 1'b1;  // Wraps to 0 after eight
                    byte_done <= (bit_cnt == 3'd7);
                end
            end
        end
    end

endmodule

/* hdl/psx_defs.svh */
`ifndef PSX_DEFS_SVH
`define PSX_DEFS_SVH

// Link timing, all counts in clk cycles

// Half period of psx_clk
`define PSX_CLK_HALF 4

// att falling to the first falling psx_clk
`define PSX_ATT_SETUP 8

// Last rising psx_clk of a byte to ack going low
`define PSX_ACK_DELAY 3

// Length of the ack low pulse
`define PSX_ACK_WIDTH 4

// Longest host wait for ack to fall
`define PSX_ACK_TIMEOUT 40

// Frame layout

`define PSX_FRAME_BYTES 5  // Header, ID, 0x5A, two button bytes

// Digital pad reports this in byte 1
`define PSX_ID_DIGITAL 8'h41

`endif

/* hdl/psx_pad_emulator.sv */
`include "psx_defs.svh"

module psx_pad_emulator import psx_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         pad_present,  // Low makes the pad silent
    input  psx_buttons_t buttons,      // Live, active low
    input  logic         psx_clk,
    input  logic         att,
    output logic         data,         // Idles high
    output logic         ack           // Active low pulse after bytes 0..3
);

    localparam int CHAIN_W = `PSX_FRAME_BYTES * 8;

    // Rise detect, count update and trigger use three of the delay cycles
    localparam logic [3:0] DLY_LOAD = 4'(`PSX_ACK_DELAY - 3);
    localparam logic [3:0] WID_LAST = 4'(`PSX_ACK_WIDTH - 1);
    localparam logic [2:0] LAST_ACK = 3'(`PSX_FRAME_BYTES - 1);

    localparam psx_byte_t HDR_BYTE = 8'hFF;
    localparam psx_byte_t RDY_BYTE = 8'h5A;

    logic               psx_clk_q;  // Previous psx_clk for edge detect
    logic               att_q;      // Registered att
    logic               idle;       // Outside a frame or no pad
    logic               fall_det;
    logic               rise_det;
    logic [CHAIN_W-1:0] chain;      // Response bits, next one at bit 0
    psx_bitcnt_t        bitcnt;     // Rising edges in this frame
    logic [2:0]         ack_idx;    // Next byte boundary to ack
    logic               ack_trig;
    logic               ack_pend;   // Delay running
    logic [3:0]         dly_cnt;
    logic [3:0]         wid_cnt;

    assign idle     = att_q || !pad_present;
    assign fall_det = psx_clk_q && !psx_clk;
    assign rise_det = !psx_clk_q && psx_clk;

    // Byte boundary reached and not yet acked
    assign ack_trig = (bitcnt[2:0] == 3'd0) && (bitcnt[5:3] == ack_idx) &&
                      (ack_idx <= LAST_ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            psx_clk_q <= 1'b1;
            att_q     <= 1'b1;
        end else begin
            psx_clk_q <= psx_clk;
            att_q     <= att;
        end
    end

    // Preload tracks the buttons until att falls
    always_ff @(posedge clk) begin
        if (idle) begin
            chain <= {buttons, RDY_BYTE, `PSX_ID_DIGITAL, HDR_BYTE};  // Header goes first
        end else if (fall_det) begin
            chain <= {1'b1, chain[CHAIN_W-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || idle) begin
            data   <= 1'b1;
            bitcnt <= '0;
        end else begin
            if (fall_det) begin
                data <= chain[0];  // Settles well before the rise
            end
            if (rise_det) begin
                bitcnt <= bitcnt + 1'b1;
            end
        end
    end

    // Ack pulse after each of the first four bytes
    always_ff @(posedge clk) begin
        if (rst || idle) begin
            ack      <= 1'b1;
            ack_idx  <= 3'd1;  // First ack at eight bits
            ack_pend <= 1'b0;
            dly_cnt  <= '0;
            wid_cnt  <= '0;
        end else begin
            if (ack_trig) begin
                ack_idx  <= ack_idx + 1'b1;  // Once per byte
                ack_pend <= 1'b1;
                dly_cnt  <= DLY_LOAD;
            end else if (ack_pend) begin
                if (dly_cnt == '0) begin
                    ack      <= 1'b0;
                    ack_pend <= 1'b0;
                    wid_cnt  <= '0;
                end else begin
                    dly_cnt <= dly_cnt - 1'b1;
                end
            end
            if (!ack) begin
                if (wid_cnt == WID_LAST) begin
                    ack <= 1'b1;  // End of pulse
                end else begin
                    wid_cnt <= wid_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/psx_pad_link.sv */
module psx_pad_link import psx_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             poll,
    input  logic             pad_present,
    input  psx_buttons_t     buttons,
    output logic             busy,
    output logic             done,
    output psx_poll_result_t result,
    output logic             att,      // Bus pins from here on
    output logic             psx_clk,
    output logic             cmd,
    output logic             data,
    output logic             ack
);

    logic      run;
    logic      fall_stb;
    logic      rise_stb;
    logic      load;
    logic      byte_done;
    psx_byte_t tx_byte;
    psx_byte_t rx_byte;

    // Host side
    psx_poll_ctrl u_poll_ctrl (
        .clk       (clk),
        .rst       (rst),
        .poll      (poll),
        .fall_stb  (fall_stb),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .ack       (ack),
        .run       (run),
        .load      (load),
        .tx_byte   (tx_byte),
        .att       (att),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    psx_bit_clock u_bit_clock (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .psx_clk  (psx_clk),
        .fall_stb (fall_stb),
        .rise_stb (rise_stb)
    );

    psx_byte_shifter u_byte_shifter (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .tx_byte   (tx_byte),
        .fall_stb  (fall_stb),
        .rise_stb  (rise_stb),
        .data      (data),
        .cmd       (cmd),
        .rx_byte   (rx_byte),
        .byte_done (byte_done)
    );

    // Pad side, cmd is not read
    psx_pad_emulator u_pad_emulator (
        .clk         (clk),
        .rst         (rst),
        .pad_present (pad_present),
        .buttons     (buttons),
        .psx_clk     (psx_clk),
        .att         (att),
        .data        (data),
        .ack         (ack)
    );

endmodule

/* hdl/psx_pkg.sv */
package psx_pkg;

    // One byte on the link, sent LSB first
    typedef logic [7:0] psx_byte_t;

    // Button word in frame order, active low
    // Bit 0 is select, bit 15 is square
    typedef logic [15:0] psx_buttons_t;

    // Bits moved so far in a frame, up to 40
    typedef logic [5:0] psx_bitcnt_t;

    // What one poll reports
    typedef struct packed {
        logic         pad_ok;   // Acks all seen and digital ID
        psx_byte_t    id;       // 0xFF when no pad
        psx_buttons_t buttons;  // All ones when no pad
    } psx_poll_result_t;

    // Host poller sequence
    typedef enum logic [2:0] {
        IDLE,       // att high, waiting for poll
        ATT_SETUP,  // att low, psx_clk not yet running
        XFER,       // Eight clock pairs of one byte
        ACK_WAIT,   // Between bytes, waiting on the pad
        FINISH      // att back up, result out
    } psx_host_state_t;

endpackage

/* hdl/psx_poll_ctrl.sv */
`include "psx_defs.svh"

module psx_poll_ctrl import psx_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             poll,       // Start strobe, dropped while busy
    input  logic             fall_stb,
    input  logic             byte_done,
    input  psx_byte_t        rx_byte,
    input  logic             ack,        // Active low from the pad
    output logic             run,        // Bit clock enable
    output logic             load,       // Shifter takes tx_byte
    output psx_byte_t        tx_byte,
    output logic             att,        // Active low select
    output logic             busy,
    output logic             done,       // Result valid strobe
    output psx_poll_result_t result
);

    // Timer covers the ack timeout, the longest count
    localparam int TMR_W = $clog2(`PSX_ACK_TIMEOUT + 1);

    // Bit clock adds a half period of its own before the first fall
    localparam logic [TMR_W-1:0] SETUP_LAST = TMR_W'(`PSX_ATT_SETUP - `PSX_CLK_HALF);
    localparam logic [TMR_W-1:0] TMO_LAST   = TMR_W'(`PSX_ACK_TIMEOUT - 1);
    localparam logic [2:0]       LAST_BYTE  = 3'(`PSX_FRAME_BYTES - 1);

    localparam psx_byte_t CMD_START = 8'h01;
    localparam psx_byte_t CMD_POLL  = 8'h42;
    localparam psx_byte_t CMD_IDLE  = 8'h00;

    psx_host_state_t  state;
    logic [2:0]       byte_idx;    // Position in the frame
    logic [TMR_W-1:0] tmr;         // Setup and ack wait timer
    logic             setup_done;  // att setup elapsed, clock may start
    logic             ack_seen;    // ack went low in this wait
    logic             ack_fail;    // A wait timed out
    logic             pad_ok;
    psx_byte_t        id_q;        // Byte 1
    psx_buttons_t     btn_q;       // Bytes 3 and 4

    assign setup_done = (tmr == SETUP_LAST);
    assign pad_ok     = !ack_fail && (id_q == `PSX_ID_DIGITAL);

    // Clock runs through a byte and the tail of att setup
    assign run = (state == XFER) || ((state == ATT_SETUP) && setup_done);

    always_comb begin
        case (byte_idx)
            3'd0:    tx_byte = CMD_START;
            3'd1:    tx_byte = CMD_POLL;
            default: tx_byte = CMD_IDLE;  // Pad ignores these anyway
        endcase
    end

    // Response capture
    always_ff @(posedge clk) begin
        if ((state == XFER) && byte_done) begin
            case (byte_idx)
                3'd1:    id_q        <= rx_byte;
                3'd3:    btn_q[7:0]  <= rx_byte;  // Select..left
                3'd4:    btn_q[15:8] <= rx_byte;  // L2..square
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            att      <= 1'b1;
            busy     <= 1'b0;
            done     <= 1'b0;
            load     <= 1'b0;
            byte_idx <= '0;
            tmr      <= '0;
            ack_seen <= 1'b0;
            ack_fail <= 1'b0;
            result   <= '0;
        end else begin
            done <= 1'b0;
            load <= 1'b0;
            case (state)
                IDLE: begin
                    if (poll) begin
                        state    <= ATT_SETUP;
                        att      <= 1'b0;  // Low on the next cycle
                        busy     <= 1'b1;
                        load     <= 1'b1;  // First command byte
                        byte_idx <= '0;
                        tmr      <= '0;
                        ack_fail <= 1'b0;
                    end
                end
                ATT_SETUP: begin
                    if (fall_stb) begin
                        state <= XFER;  // First bit is on its way
                    end else if (!setup_done) begin
                        tmr <= tmr + 1'b1;
                    end
                end
                XFER: begin
                    if (byte_done) begin
                        if (byte_idx == LAST_BYTE) begin
                            state <= FINISH;  // No ack after the last byte
                        end else begin
                            state    <= ACK_WAIT;
                            tmr      <= '0;
                            ack_seen <= 1'b0;
                        end
                    end
                end
                ACK_WAIT: begin
                    if (!ack_seen) begin
                        if (!ack) begin
                            ack_seen <= 1'b1;
                        end else if (tmr == TMO_LAST) begin
                            ack_fail <= 1'b1;  // No pad answered
                            state    <= FINISH;
                        end else begin
                            tmr <= tmr + 1'b1;
                        end
                    end else if (ack) begin
                        // ack back high, next byte
                        state    <= XFER;
                        load     <= 1'b1;
                        byte_idx <= byte_idx + 1'b1;
                    end
                end
                FINISH: begin
                    state          <= IDLE;
                    att            <= 1'b1;
                    busy           <= 1'b0;
                    done           <= 1'b1;
                    result.pad_ok  <= pad_ok;
                    result.id      <= pad_ok ? id_q : 8'hFF;
                    result.buttons <= pad_ok ? btn_q : '1;  // Nothing pressed
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* test/tb_psx_pad_link.sv */
`include "psx_defs.svh"

module tb_psx_pad_link import psx_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int FRAMES     = 15;  // 12 with the pad, 3 without
    localparam int ACKS       = `PSX_FRAME_BYTES - 1;  // No ack after the last byte

    // Worst frame: setup, all bit clocks, every ack wait at its limit plus restart
    localparam int FRAME_MAX = `PSX_ATT_SETUP + `PSX_FRAME_BYTES * 16 * `PSX_CLK_HALF +
                               ACKS * (`PSX_ACK_TIMEOUT + `PSX_ACK_WIDTH +
                               2 * `PSX_CLK_HALF) + 16;
    localparam int WATCHDOG_CYCLES = FRAMES * (FRAME_MAX + 8) + 100;

    logic             clk;
    logic             rst;
    logic             poll;
    logic             pad_present;
    psx_buttons_t     buttons;
    logic             busy;
    logic             done;
    psx_poll_result_t result;
    logic             att;
    logic             psx_clk;
    logic             cmd;
    logic             data;
    logic             ack;

    int   value_errors = 0;
    int   other_errors = 0;
    int   frames_started = 0;  // Polls issued while the link was idle
    int   done_cnt;
    int   ack_cnt;             // Ack pulses since att last fell
    int   rise_cnt;            // psx_clk rises since att last fell
    logic att_prev;
    logic ack_prev;
    logic psx_clk_prev;
    logic polled = 1'b0;       // First poll has gone out

    psx_pad_link DUT (
        .clk         (clk),
        .rst         (rst),
        .poll        (poll),
        .pad_present (pad_present),
        .buttons     (buttons),
        .busy        (busy),
        .done        (done),
        .result      (result),
        .att         (att),
        .psx_clk     (psx_clk),
        .cmd         (cmd),
        .data        (data),
        .ack         (ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        value_errors++;
        $display("error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic wait_for_done(input int target, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b1;
        while (done_cnt < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > FRAME_MAX) begin
                other_errors++;
                $display("poll %0d got no done within %0d cycles", target, FRAME_MAX);
                ok = 1'b0;
                break;
            end
        end
    endtask

    // Host command bit at a frame position: 0x01, 0x42, then 0x00
    function automatic logic expected_cmd_bit(input int idx);
        logic [7:0] b;
        case (idx / 8)
            0:       b = 8'h01;
            1:       b = 8'h42;
            default: b = 8'h00;
        endcase
        return b[idx % 8];
    endfunction

    // Pad response bit at a frame position, line stays high with no pad
    function automatic logic expected_data_bit(input int idx, input logic present,
                                               input psx_buttons_t btn);
        logic [7:0] b;
        case (idx / 8)
            0:       b = 8'hFF;
            1:       b = `PSX_ID_DIGITAL;
            2:       b = 8'h5A;
            3:       b = btn[7:0];   // Select..left
            default: b = btn[15:8];  // L2..square
        endcase
        return present ? b[idx % 8] : 1'b1;
    endfunction

    // Ack, bit and done tracker, edges seen on sampled bus values
    always @(posedge clk) begin
        if (rst) begin
            att_prev     <= 1'b1;
            ack_prev     <= 1'b1;
            psx_clk_prev <= 1'b1;
            ack_cnt      <= 0;
            rise_cnt     <= 0;
            done_cnt     <= 0;
        end else begin
            att_prev     <= att;
            ack_prev     <= ack;
            psx_clk_prev <= psx_clk;
            if (att_prev && !att) begin
                ack_cnt  <= 0;  // New frame
                rise_cnt <= 0;
            end else begin
                if (ack_prev && !ack) begin
                    ack_cnt <= ack_cnt + 1;
                end
                if (!psx_clk_prev && psx_clk) begin
                    rise_cnt <= rise_cnt + 1;  // Next bit position
                end
            end
            if (done) done_cnt <= done_cnt + 1;
        end
    end

    // Idle state from reset until the first poll
    a_idle_att:     assert property (@(posedge clk) disable iff (rst) !polled |-> att)
        else report_value("att", 1, $sampled(att));
    a_idle_psx_clk: assert property (@(posedge clk) disable iff (rst) !polled |-> psx_clk)
        else report_value("psx_clk", 1, $sampled(psx_clk));
    a_idle_busy:    assert property (@(posedge clk) disable iff (rst) !polled |-> !busy)
        else report_value("busy", 0, $sampled(busy));
    a_idle_done:    assert property (@(posedge clk) disable iff (rst) !polled |-> !done)
        else report_value("done", 0, $sampled(done));
    a_idle_result:  assert property (@(posedge clk) disable iff (rst) !polled |-> result == '0)
        else report_value("result", 0, $sampled(result));

    // Bus bits at each psx_clk rise, LSB first
    a_cmd_bit: assert property (@(posedge clk) disable iff (rst)
        $rose(psx_clk) |-> cmd == expected_cmd_bit(rise_cnt))
        else report_value("cmd", expected_cmd_bit($sampled(rise_cnt)), $sampled(cmd));
    a_data_bit: assert property (@(posedge clk) disable iff (rst)
        $rose(psx_clk) |-> data == expected_data_bit(rise_cnt, pad_present, buttons))
        else report_value("data",
            expected_data_bit($sampled(rise_cnt), $sampled(pad_present), $sampled(buttons)),
            $sampled(data));

    // Pad present, result follows the held buttons
    a_ok_flag: assert property (@(posedge clk) disable iff (rst)
        done && pad_present |-> result.pad_ok)
        else report_value("result.pad_ok", 1, $sampled(result.pad_ok));
    a_ok_id: assert property (@(posedge clk) disable iff (rst)
        done && pad_present |-> result.id == `PSX_ID_DIGITAL)
        else report_value("result.id", `PSX_ID_DIGITAL, $sampled(result.id));
    a_ok_buttons: assert property (@(posedge clk) disable iff (rst)
        done && pad_present |-> result.buttons == buttons)
        else report_value("result.buttons", $sampled(buttons), $sampled(result.buttons));

    // Pad absent, fixed no-pad result
    a_nopad_flag: assert property (@(posedge clk) disable iff (rst)
        done && !pad_present |-> !result.pad_ok)
        else report_value("result.pad_ok", 0, $sampled(result.pad_ok));
    a_nopad_id: assert property (@(posedge clk) disable iff (rst)
        done && !pad_present |-> result.id == 8'hFF)
        else report_value("result.id", 8'hFF, $sampled(result.id));
    a_nopad_buttons: assert property (@(posedge clk) disable iff (rst)
        done && !pad_present |-> result.buttons == 16'hFFFF)
        else report_value("result.buttons", 16'hFFFF, $sampled(result.buttons));

    a_ack_count: assert property (@(posedge clk) disable iff (rst)
        done |-> ack_cnt == (pad_present ? ACKS : 0))
        else report_value("ack_cnt", pad_present ? ACKS : 0, $sampled(ack_cnt));

    a_clk_att: assert property (@(posedge clk) disable iff (rst)
        psx_clk != $past(psx_clk) |-> !att)
        else begin
            other_errors++;
            $display("psx_clk toggled at %0t while att was high", $time);
        end

    a_done_att: assert property (@(posedge clk) disable iff (rst) done |-> att)
        else report_value("att", 1, $sampled(att));
    a_done_extra: assert property (@(posedge clk) disable iff (rst)
        done |-> done_cnt < frames_started)
        else begin
            other_errors++;
            $display("done at %0t has no poll of its own", $time);
        end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog ran out after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        bit ok;
        rst         = 1'b1;
        poll        = 1'b0;
        pad_present = 1'b1;
        buttons     = '1;  // Nothing pressed
        void'($urandom(54630));
        repeat (3) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        for (int i = 0; i < FRAMES; i++) begin
            @(negedge clk);
            pad_present = (i % 5 != 4);  // Every fifth poll with no pad
            buttons     = psx_buttons_t'($urandom);
            poll        = 1'b1;
            polled      = 1'b1;
            frames_started++;
            @(negedge clk);
            poll = 1'b0;
            repeat (2 + $urandom % 60) @(negedge clk);
            if (busy) begin
                poll = 1'b1;  // Strobe to be ignored
                @(negedge clk);
                poll = 1'b0;
            end
            wait_for_done(i + 1, ok);
            if (!ok) break;
            repeat ($urandom % 5) @(negedge clk);
        end
        repeat (10) @(negedge clk);
        if (done_cnt != frames_started) report_value("done_cnt", frames_started, done_cnt);
        $display("checks over: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
